// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_int_pipe -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_int_pipe.sv
`timescale 1ns/1ps

module tb_int_pipe;

  localparam int NUM_DIRECTED = 7;
  localparam int NUM_RANDOM   = 400;
  localparam int DRAIN        = 4;
  // one slot per cycle, idle slots included.
  localparam int MAX_CYCLES   = NUM_DIRECTED + NUM_RANDOM + 50;

  typedef struct packed {
    logic             wb;
    rv_pkg::reg_idx_t rd;
    rv_pkg::xlen_t    data;
    logic             br;
    rv_pkg::addr_t    target;
  } expect_t;

  logic             clk;
  logic             rst;
  logic             instr_valid;
  rv_pkg::instr_u   instr;
  rv_pkg::addr_t    pc;
  logic             wb_valid;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::xlen_t    wb_data;
  logic             br_taken;
  rv_pkg::addr_t    br_target;

  logic [31:0]   arch_regs [32];
  logic [31:0]   rng_state = 32'hea12;
  rv_pkg::addr_t next_pc   = '0;
  expect_t       wb_q [$];
  expect_t       br_issue  = '0;  // branch outcome of the word driven this edge.
  expect_t       br_slot   = '0;
  expect_t       head;
  int            errors    = 0;
  int            cycles    = 0;

  int_pipe_top i_dut
    ( .clk         ( clk         )
    , .rst         ( rst         )
    , .instr_valid ( instr_valid )
    , .instr       ( instr       )
    , .pc          ( pc          )
    , .wb_valid    ( wb_valid    )
    , .wb_rd       ( wb_rd       )
    , .wb_data     ( wb_data     )
    , .br_taken    ( br_taken    )
    , .br_target   ( br_target   )
    );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // rv32i integer semantics by funct3.
  function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0: begin
        if (alt) return a - b;
        return a + b;
      end
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // executes one word in program order on the architectural registers.
  function automatic expect_t model_step(rv_pkg::instr_u w, rv_pkg::addr_t at);
    expect_t     e;
    logic [31:0] raw;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    raw  = w;
    e    = '0;
    e.rd = raw[11:7];
    a    = arch_regs[raw[19:15]];
    b    = arch_regs[raw[24:20]];
    case (raw[6:0])
      rv_pkg::OPC_OP: begin
        e.wb   = 1'b1;
        e.data = ref_alu(raw[14:12], raw[30], a, b);
      end
      rv_pkg::OPC_OP_IMM: begin
        imm    = {{20{raw[31]}}, raw[31:20]};
        e.wb   = 1'b1;
        e.data = ref_alu(raw[14:12], raw[30] && raw[14:12] == 3'd5, a, imm);
      end
      rv_pkg::OPC_LUI: begin
        e.wb   = 1'b1;
        e.data = {raw[31:12], 12'b0};
      end
      rv_pkg::OPC_BRANCH: begin
        imm      = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
        e.br     = branch_holds(raw[14:12], a, b);
        e.target = at + imm;
      end
      rv_pkg::OPC_JAL: begin
        imm      = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
        e.wb     = 1'b1;
        e.data   = at + 32'd4;  // link.
        e.br     = 1'b1;
        e.target = at + imm;
      end
      default: ;  // no-op.
    endcase
    if (e.rd == 5'd0) e.wb = 1'b0;
    if (e.wb) arch_regs[e.rd] = e.data;
    return e;
  endfunction

  function automatic rv_pkg::instr_u enc_r(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
                                           rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rd);
    rv_pkg::instr_u w;
    w = '0;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.rd     = rd;
    w.r.opcode = rv_pkg::OPC_OP;  // funct3 0, add or sub.
    return w;
  endfunction

  function automatic rv_pkg::instr_u enc_addi(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
                                              rv_pkg::reg_idx_t rd);
    rv_pkg::instr_u w;
    w = '0;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.rd     = rd;
    w.i.opcode = rv_pkg::OPC_OP_IMM;
    return w;
  endfunction

  // registers x0..x7 only, so hazards come up often.
  function automatic rv_pkg::instr_u random_instr();
    rv_pkg::instr_u w;
    logic [31:0]    r;
    int unsigned    sel;
    sel = next_rand() % 6;
    r   = next_rand();
    w   = '0;
    w.r.rd     = {2'b0, r[2:0]};
    w.r.rs1    = {2'b0, r[5:3]};
    w.r.rs2    = {2'b0, r[8:6]};
    w.r.funct3 = r[11:9];
    case (sel)
      0: begin
        w.r.opcode = rv_pkg::OPC_OP;
        if (r[12] && (r[11:9] == 3'd0 || r[11:9] == 3'd5)) w.r.funct7 = 7'h20;
      end
      1: begin
        w.i.opcode = rv_pkg::OPC_OP_IMM;
        w.i.imm12  = r[31:20];
        if (r[11:9] == 3'd1) w.i.imm12 = {7'h00, r[24:20]};
        if (r[11:9] == 3'd5) w.i.imm12 = {r[12] ? 7'h20 : 7'h00, r[24:20]};
      end
      2, 4: begin
        w.j.opcode   = (sel == 2) ? rv_pkg::OPC_LUI : rv_pkg::OPC_JAL;
        w.j.imm20    = r[31];
        w.j.imm10_1  = r[30:21];
        w.j.imm11    = r[20];
        w.j.imm19_12 = r[19:12];
      end
      3: begin
        w.b.opcode  = rv_pkg::OPC_BRANCH;
        w.b.imm12   = r[31];
        w.b.imm10_5 = r[30:25];
        w.b.imm4_1  = r[16:13];
        w.b.imm11   = r[17];
        if (w.b.funct3[2:1] == 2'b01) w.b.funct3 = w.b.funct3 + 3'd2;  // skip reserved.
      end
      default: w.r.opcode = 7'b0000011;  // load, not supported here.
    endcase
    return w;
  endfunction

  task automatic issue(logic valid, rv_pkg::instr_u w);
    expect_t e;
    e = '0;
    if (valid) begin
      e = model_step(w, next_pc);
      if (e.wb) wb_q.push_back(e);
      instr <= w;
    end else begin
      instr <= rv_pkg::NOP_WORD;
    end
    instr_valid <= valid;
    pc          <= next_pc;
    br_issue    <= e;
    if (valid) next_pc = next_pc + 32'd4;
    @(posedge clk);
  endtask

  // branch seen two edges after drive, write-back three.
  always @(posedge clk) begin
    if (!rst) begin
      br_slot <= br_issue;
      check_val("br_taken", {31'b0, br_taken}, {31'b0, br_slot.br});
      if (br_slot.br) check_val("br_target", br_target, br_slot.target);
      if (wb_valid) begin
        if (wb_q.size() == 0) begin
          errors++;
          $display("write-back to x%0d at %0t with none expected", wb_rd, $time);
        end else begin
          head = wb_q.pop_front();
          check_val("wb_rd", {27'b0, wb_rd}, {27'b0, head.rd});
          check_val("wb_data", wb_data, head.data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, stimulus never finished", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] gap;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = rv_pkg::NOP_WORD;
    pc          = '0;
    for (int i = 0; i < 32; i++) begin
      arch_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    check_val("wb_valid", {31'b0, wb_valid}, 32'd0);  // quiet in reset.
    check_val("br_taken", {31'b0, br_taken}, 32'd0);
    rst <= 1'b0;

    issue(1'b1, enc_r(7'h00, 5'd7, 5'd6, 5'd5));   // add x5, x6, x7 before any write.
    issue(1'b1, enc_addi(12'd5, 5'd0, 5'd1));
    issue(1'b1, enc_addi(12'hffd, 5'd1, 5'd2));     // -3, x1 forwarded.
    issue(1'b1, enc_r(7'h00, 5'd2, 5'd1, 5'd3));    // x1 two back, x2 one back.
    issue(1'b1, enc_r(7'h20, 5'd1, 5'd3, 5'd4));    // sub.
    issue(1'b1, enc_addi(12'd7, 5'd1, 5'd0));       // x0 target, no write-back.
    issue(1'b1, enc_r(7'h00, 5'd4, 5'd0, 5'd6));

    for (int n = 0; n < NUM_RANDOM; n++) begin
      gap = next_rand();
      issue(gap[2:0] != 3'd0, random_instr());
    end
    repeat (DRAIN) issue(1'b0, rv_pkg::NOP_WORD);
    @(negedge clk);

    if (wb_q.size() != 0) begin
      $display("%0d expected write-backs never showed up", wb_q.size());
      errors += wb_q.size();
    end
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu
  ( input  rv_pkg::xlen_t   a
  , input  rv_pkg::xlen_t   b
  , input  rv_pkg::alu_op_e alu_op
  , output rv_pkg::xlen_t   result
  , output logic            zero
  );

  logic [4:0] shamt;

  assign shamt = b[4:0];  // shifts only see the low bits.

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    result = a + b;
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_AND:    result = a & b;
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_SLL:    result = a << shamt;
      rv_pkg::ALU_SRL:    result = a >> shamt;
      rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
      rv_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU:   result = {31'b0, a < b};
      rv_pkg::ALU_PASS_B: result = b;  // lui.
      default:            result = '0;
    endcase
  end

  // used by beq and bne after a subtract.
  assign zero = (result == '0);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  ( input  logic              clk
  , input  logic              rst
  , input  logic              instr_valid
  , input  rv_pkg::instr_u    instr
  , input  rv_pkg::addr_t     pc
  , output rv_pkg::reg_idx_t  rs1
  , output rv_pkg::reg_idx_t  rs2
  , input  rv_pkg::xlen_t     rd1
  , input  rv_pkg::xlen_t     rd2
  , output rv_pkg::id_to_ex_t id_to_ex
  );

  rv_pkg::instr_u    word;
  rv_pkg::opcode_e   opcode;
  rv_pkg::id_to_ex_t id_d;

  // funct3 to alu op, alt picks sub or sra.
  function automatic rv_pkg::alu_op_e arith_op(logic [2:0] funct3, logic alt);
    case (funct3)
      3'b000: begin
        if (alt) return rv_pkg::ALU_SUB;
        return rv_pkg::ALU_ADD;
      end
      3'b001: return rv_pkg::ALU_SLL;
      3'b010: return rv_pkg::ALU_SLT;
      3'b011: return rv_pkg::ALU_SLTU;
      3'b100: return rv_pkg::ALU_XOR;
      3'b101: begin
        if (alt) return rv_pkg::ALU_SRA;
        return rv_pkg::ALU_SRL;
      end
      3'b110: return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rv_pkg::branch_e branch_kind(logic [2:0] funct3);
    case (funct3)
      3'b000: return rv_pkg::BR_EQ;
      3'b001: return rv_pkg::BR_NE;
      3'b100: return rv_pkg::BR_LT;
      3'b101: return rv_pkg::BR_GE;
      3'b110: return rv_pkg::BR_LTU;
      3'b111: return rv_pkg::BR_GEU;
      default: return rv_pkg::BR_NONE;  // reserved funct3.
    endcase
  endfunction

  // idle slots decode as a nop.
  assign word   = instr_valid ? instr : rv_pkg::NOP_WORD;
  assign opcode = rv_pkg::opcode_e'(word.r.opcode);
  assign rs1    = word.r.rs1;
  assign rs2    = word.r.rs2;

  always_comb begin
    id_d            = '0;
    id_d.valid      = instr_valid;
    id_d.pc         = pc;
    id_d.rd         = word.r.rd;
    id_d.rs1        = word.r.rs1;
    id_d.rs2        = word.r.rs2;
    id_d.rd1        = rd1;
    id_d.rd2        = rd2;
    id_d.alu_op     = rv_pkg::ALU_ADD;
    id_d.alu_src_b  = rv_pkg::SRC_B_RS2;
    id_d.branch     = rv_pkg::BR_NONE;
    id_d.result_src = rv_pkg::RES_ALU;
    case (opcode)
      rv_pkg::OPC_OP: begin
        id_d.alu_op    = arith_op(word.r.funct3, word.r.funct7[5]);
        id_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        id_d.imm_ext   = {{20{word.i.imm12[11]}}, word.i.imm12};
        // only srai uses bit 30; addi has no subtract form.
        id_d.alu_op    = arith_op(word.i.funct3, word.r.funct7[5] && word.i.funct3 == 3'b101);
        id_d.alu_src_b = rv_pkg::SRC_B_IMM;
        id_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        id_d.imm_ext   = {word.j.imm20, word.j.imm10_1, word.j.imm11, word.j.imm19_12, 12'b0};
        id_d.alu_op    = rv_pkg::ALU_PASS_B;
        id_d.alu_src_b = rv_pkg::SRC_B_IMM;
        id_d.reg_write = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        id_d.imm_ext = {{20{word.b.imm12}}, word.b.imm11, word.b.imm10_5, word.b.imm4_1, 1'b0};
        id_d.branch  = branch_kind(word.b.funct3);
        case (id_d.branch)
          rv_pkg::BR_LT, rv_pkg::BR_GE:   id_d.alu_op = rv_pkg::ALU_SLT;
          rv_pkg::BR_LTU, rv_pkg::BR_GEU: id_d.alu_op = rv_pkg::ALU_SLTU;
          default:                        id_d.alu_op = rv_pkg::ALU_SUB;
        endcase
      end
      rv_pkg::OPC_JAL: begin
        id_d.imm_ext    = {{12{word.j.imm20}}, word.j.imm19_12, word.j.imm11,
                           word.j.imm10_1, 1'b0};
        id_d.branch     = rv_pkg::BR_ALWAYS;
        id_d.result_src = rv_pkg::RES_PC_PLUS4;  // link address.
        id_d.reg_write  = 1'b1;
      end
      default: ;  // unsupported, no write and no branch.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_to_ex.valid     <= 1'b0;
      id_to_ex.reg_write <= 1'b0;
      id_to_ex.branch    <= rv_pkg::BR_NONE;
    end else begin
      id_to_ex <= id_d;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(id_to_ex.valid));

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  ( input  logic               clk
  , input  logic               rst
  , input  rv_pkg::id_to_ex_t  id_to_ex
  , input  rv_pkg::wb_port_t   wb
  , output logic               br_taken
  , output rv_pkg::addr_t      br_target
  , output rv_pkg::ex_to_res_t ex_to_res
  );

  rv_pkg::fwd_sel_e   fwd_a;
  rv_pkg::fwd_sel_e   fwd_b;
  rv_pkg::xlen_t      src_a;
  rv_pkg::xlen_t      rs2_val;
  rv_pkg::xlen_t      src_b;
  rv_pkg::xlen_t      alu_result;
  logic               alu_zero;
  logic               cond;
  rv_pkg::ex_to_res_t ex_d;

  // the result register is the only bypass source.
  function automatic rv_pkg::fwd_sel_e fwd_select(rv_pkg::reg_idx_t rs, rv_pkg::wb_port_t port);
    if (port.we && port.rd == rs && rs != '0) return rv_pkg::FWD_RESULT;
    return rv_pkg::FWD_REG;
  endfunction

  assign fwd_a = fwd_select(id_to_ex.rs1, wb);
  assign fwd_b = fwd_select(id_to_ex.rs2, wb);

  always_comb begin
    case (fwd_a)
      rv_pkg::FWD_RESULT: src_a = wb.data;
      default:            src_a = id_to_ex.rd1;
    endcase
    case (fwd_b)
      rv_pkg::FWD_RESULT: rs2_val = wb.data;
      default:            rs2_val = id_to_ex.rd2;
    endcase
    case (id_to_ex.alu_src_b)
      rv_pkg::SRC_B_IMM: src_b = id_to_ex.imm_ext;
      default:           src_b = rs2_val;
    endcase
  end

  alu i_alu
    ( .a      ( src_a           )
    , .b      ( src_b           )
    , .alu_op ( id_to_ex.alu_op )
    , .result ( alu_result      )
    , .zero   ( alu_zero        )
    );

  // compares reuse the alu with sub for eq/ne and slt(u) for the rest.
  always_comb begin
    case (id_to_ex.branch)
      rv_pkg::BR_EQ:                 cond = alu_zero;
      rv_pkg::BR_NE:                 cond = !alu_zero;
      rv_pkg::BR_LT, rv_pkg::BR_LTU: cond = alu_result[0];
      rv_pkg::BR_GE, rv_pkg::BR_GEU: cond = !alu_result[0];
      rv_pkg::BR_ALWAYS:             cond = 1'b1;
      default:                       cond = 1'b0;
    endcase
  end

  assign br_taken  = id_to_ex.valid && cond;
  assign br_target = id_to_ex.pc + id_to_ex.imm_ext;

  always_comb begin
    ex_d.valid      = id_to_ex.valid;
    ex_d.rd         = id_to_ex.rd;
    ex_d.reg_write  = id_to_ex.reg_write;
    ex_d.result_src = id_to_ex.result_src;
    ex_d.alu_result = alu_result;
    ex_d.pc_plus4   = id_to_ex.pc + 32'd4;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_to_res.valid     <= 1'b0;
      ex_to_res.reg_write <= 1'b0;
    end else begin
      ex_to_res <= ex_d;
    end
  end

  // a reported redirect always carries a usable target.
  a_br_target_known: assert property (@(posedge clk) disable iff (rst)
    br_taken |-> !$isunknown(br_target));

endmodule

// File: design/int_pipe_top.sv
`timescale 1ns/1ps

module int_pipe_top
  ( input  logic             clk
  , input  logic             rst
  , input  logic             instr_valid
  , input  rv_pkg::instr_u   instr
  , input  rv_pkg::addr_t    pc
  , output logic             wb_valid
  , output rv_pkg::reg_idx_t wb_rd
  , output rv_pkg::xlen_t    wb_data
  , output logic             br_taken
  , output rv_pkg::addr_t    br_target
  );

  rv_pkg::reg_idx_t   rs1;
  rv_pkg::reg_idx_t   rs2;
  rv_pkg::xlen_t      rd1;
  rv_pkg::xlen_t      rd2;
  rv_pkg::id_to_ex_t  id_to_ex;
  rv_pkg::ex_to_res_t ex_to_res;
  rv_pkg::wb_port_t   wb;  // write-back and forwarding source.

  reg_file i_reg_file
    ( .clk ( clk )
    , .rst ( rst )
    , .rs1 ( rs1 )
    , .rs2 ( rs2 )
    , .rd1 ( rd1 )
    , .rd2 ( rd2 )
    , .wb  ( wb  )
    );

  decode_stage i_decode
    ( .clk         ( clk         )
    , .rst         ( rst         )
    , .instr_valid ( instr_valid )
    , .instr       ( instr       )
    , .pc          ( pc          )
    , .rs1         ( rs1         )
    , .rs2         ( rs2         )
    , .rd1         ( rd1         )
    , .rd2         ( rd2         )
    , .id_to_ex    ( id_to_ex    )
    );

  execute_stage i_execute
    ( .clk       ( clk       )
    , .rst       ( rst       )
    , .id_to_ex  ( id_to_ex  )
    , .wb        ( wb        )
    , .br_taken  ( br_taken  )
    , .br_target ( br_target )
    , .ex_to_res ( ex_to_res )
    );

  result_stage i_result
    ( .ex_to_res ( ex_to_res )
    , .wb        ( wb        )
    , .wb_valid  ( wb_valid  )
    , .wb_rd     ( wb_rd     )
    , .wb_data   ( wb_data   )
    );

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file
  ( input  logic             clk
  , input  logic             rst
  , input  rv_pkg::reg_idx_t rs1
  , input  rv_pkg::reg_idx_t rs2
  , output rv_pkg::xlen_t    rd1
  , output rv_pkg::xlen_t    rd2
  , input  rv_pkg::wb_port_t wb
  );

  rv_pkg::xlen_t regs [rv_pkg::NUM_REGS];

  // write-through so a reader two behind sees the new value.
  function automatic rv_pkg::xlen_t read_port(rv_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    if (wb.we && wb.rd == idx) return wb.data;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rd1 = read_port(rs1);
  assign rd2 = read_port(rs2);

  // result stage must never ask for a write to x0.
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wb.we |-> wb.rd != '0);
  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

// File: design/result_stage.sv
`timescale 1ns/1ps

module result_stage
  ( input  rv_pkg::ex_to_res_t ex_to_res
  , output rv_pkg::wb_port_t   wb
  , output logic               wb_valid
  , output rv_pkg::reg_idx_t   wb_rd
  , output rv_pkg::xlen_t      wb_data
  );

  logic rd_nonzero;

  assign rd_nonzero = (ex_to_res.rd != '0);

  always_comb begin
    // x0 targets and non-writing ops drop out here.
    wb.we = ex_to_res.valid && ex_to_res.reg_write && rd_nonzero;
    wb.rd = ex_to_res.rd;
    case (ex_to_res.result_src)
      rv_pkg::RES_PC_PLUS4: wb.data = ex_to_res.pc_plus4;  // jal link.
      default:              wb.data = ex_to_res.alu_result;
    endcase
  end

  // same value goes to the top ports.
  assign wb_valid = wb.we;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int          NUM_REGS = 32;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0.

  // instruction formats, msb first.
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // lui takes the same upper 20 bits.
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
  } branch_e;

  typedef enum logic {SRC_B_RS2, SRC_B_IMM} alu_src_b_e;
  typedef enum logic {RES_ALU, RES_PC_PLUS4} result_src_e;
  typedef enum logic {FWD_REG, FWD_RESULT} fwd_sel_e;

  typedef struct packed {
    logic        valid;
    addr_t       pc;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    xlen_t       rd1;
    xlen_t       rd2;
    xlen_t       imm_ext;
    alu_op_e     alu_op;
    alu_src_b_e  alu_src_b;
    branch_e     branch;
    result_src_e result_src;
    logic        reg_write;
  } id_to_ex_t;

  typedef struct packed {
    logic        valid;
    reg_idx_t    rd;
    logic        reg_write;
    result_src_e result_src;
    xlen_t       alu_result;
    addr_t       pc_plus4;
  } ex_to_res_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    xlen_t    data;
  } wb_port_t;

endpackage

// File: flist.f
design/rv_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/result_stage.sv
design/int_pipe_top.sv
bench/tb_int_pipe.sv
